// ==== rtl/l1d_geom_pkg.sv ====
//==========================================================================
// Geometry of the L1 data cache: word and address widths, line layout
// and the vector types that carry them between modules
//==========================================================================
package l1d_geom_pkg;

  // Core word and byte address
  localparam int ADDR_BITS = 32;
  localparam int WORD_BITS = 32;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [WORD_BITS-1:0] word_t;

  // Line layout, four words of four bytes
  localparam int WORDS_PER_LINE = 4;
  localparam int OFFSET_BITS = 4;

  typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;

  // Word number within a line
  typedef logic [1:0] word_sel_t;

endpackage

// ==== rtl/l1d_bus_pkg.sv ====
//==========================================================================
// Encodings on the core and memory buses of the L1 data cache: the store
// size, the byte strobe and the controller state
//==========================================================================
package l1d_bus_pkg;

  // Store size from the core, loads always return the aligned word
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_e;

  // One bit per byte lane, bit 0 is the lowest byte
  typedef logic [3:0] strobe_t;

  // Access sequencer
  typedef enum logic [3:0] {
    ST_IDLE         = 4'd0,
    ST_LOOKUP       = 4'd1,
    ST_REFILL_ISSUE = 4'd2,
    ST_REFILL_WAIT  = 4'd3,
    ST_FILL         = 4'd4,
    ST_RESPOND      = 4'd5,
    ST_WRITE_WAIT   = 4'd6
  } ctrl_state_e;

endpackage

// ==== rtl/l1d_tag_store.sv ====
//==========================================================================
// Tag array and per-set valid bits. A lookup reads the set and registers
// the tag to compare, hit follows one cycle later. A fill installs the
// registered tag and marks the set valid
//==========================================================================
`timescale 1ns/1ns

module l1d_tag_store #(
  parameter int INDEX_BITS = 6,
  localparam int TAG_BITS = l1d_geom_pkg::ADDR_BITS - INDEX_BITS - l1d_geom_pkg::OFFSET_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lookup,
  input  logic [INDEX_BITS-1:0] index,
  input  logic [TAG_BITS-1:0]   lookup_tag,
  input  logic                  fill,
  output logic                  hit
);

  localparam int SETS = 1 << INDEX_BITS;

  logic [TAG_BITS-1:0] tags [SETS];
  logic [SETS-1:0]     valid;
  logic [TAG_BITS-1:0] tag_rd;
  logic [TAG_BITS-1:0] tag_q;
  logic                valid_rd;

  // Valid bits start clear
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid <= '0;
      valid_rd <= 1'b0;
    end
    else
    begin
      if (fill)
        valid[index] <= 1'b1;
      if (lookup)
        valid_rd <= valid[index];
    end
  end

  // Tag kept after the lookup so the refill can install it
  always_ff @(posedge clk)
  begin
    if (fill)
      tags[index] <= tag_q;
    if (lookup)
    begin
      tag_rd <= tags[index];
      tag_q <= lookup_tag;
    end
  end

  assign hit = valid_rd && (tag_rd == tag_q);

  // The controller never refills while a new lookup is being issued
  assert property (@(posedge clk) disable iff (rst) !(fill && lookup))
    else $error("tag store saw fill and lookup in one cycle");

endmodule

// ==== rtl/l1d_data_store.sv ====
//==========================================================================
// Line data array. A read returns the whole line one cycle later. A fill
// replaces the line, a store hit merges the strobed bytes of one word
//==========================================================================
`timescale 1ns/1ns

module l1d_data_store #(
  parameter int INDEX_BITS = 6
) (
  input  logic                      clk,
  input  logic [INDEX_BITS-1:0]     index,
  input  logic                      read,
  input  logic                      fill,
  input  l1d_geom_pkg::line_t       fill_line,
  input  logic                      store_hit,
  input  l1d_geom_pkg::word_sel_t   word_sel,
  input  l1d_bus_pkg::strobe_t      strobe,
  input  l1d_geom_pkg::word_t       wdata,
  output l1d_geom_pkg::line_t       line_rd
);

  localparam int SETS = 1 << INDEX_BITS;
  localparam int WORD_BITS = $bits(l1d_geom_pkg::word_t);
  localparam int LANES = $bits(l1d_bus_pkg::strobe_t);

  l1d_geom_pkg::line_t lines [SETS];

  always_ff @(posedge clk)
  begin
    if (fill)
      lines[index] <= fill_line;
    else if (store_hit)
    begin
      // Byte merge into the addressed word
      for (int b = 0; b < LANES; b++)
      begin
        if (strobe[b])
          lines[index][word_sel*WORD_BITS + b*8 +: 8] <= wdata[b*8 +: 8];
      end
    end

    if (read)
      line_rd <= lines[index];
  end

endmodule

// ==== rtl/l1d_store_align.sv ====
//==========================================================================
// Store alignment. Builds the byte strobe from the size and the low
// address bits and copies the store data into every lane
//==========================================================================
`timescale 1ns/1ns

module l1d_store_align (
  input  l1d_bus_pkg::access_size_e size,
  input  logic [1:0]                byte_addr,
  input  l1d_geom_pkg::word_t       wdata,
  output l1d_bus_pkg::strobe_t      strobe,
  output l1d_geom_pkg::word_t       lane_data
);

  always_comb
  begin
    case (size)
      l1d_bus_pkg::SIZE_BYTE:
      begin
        strobe = l1d_bus_pkg::strobe_t'(4'b0001 << byte_addr);
        lane_data = {4{wdata[7:0]}};
      end
      l1d_bus_pkg::SIZE_HALF:
      begin
        // Bit 0 plays no part for halfwords
        strobe = byte_addr[1] ? 4'b1100 : 4'b0011;
        lane_data = {2{wdata[15:0]}};
      end
      l1d_bus_pkg::SIZE_WORD:
      begin
        strobe = 4'b1111;
        lane_data = wdata;
      end
      default:
      begin
        strobe = 4'b0000;
        lane_data = wdata;
      end
    endcase
  end

  // Any legal size writes at least one lane
  always_comb
  begin
    if (size inside {l1d_bus_pkg::SIZE_BYTE, l1d_bus_pkg::SIZE_HALF, l1d_bus_pkg::SIZE_WORD})
      assert #0 (strobe != 4'b0000)
        else $error("empty byte strobe for size %0d", size);
  end

endmodule

// ==== rtl/l1d_ctrl.sv ====
//==========================================================================
// Cache controller. Latches a core access, issues the tag and data
// lookup, refills a missed line in four single-word beats and sends
// every store through to memory
//==========================================================================
`timescale 1ns/1ns

module l1d_ctrl #(
  parameter int INDEX_BITS = 6,
  localparam int TAG_BITS = l1d_geom_pkg::ADDR_BITS - INDEX_BITS - l1d_geom_pkg::OFFSET_BITS
) (
  input  logic                      clk,
  input  logic                      rst,
  // Core side
  input  logic                      core_req,
  input  logic                      core_write,
  input  l1d_geom_pkg::addr_t       core_addr,
  input  l1d_bus_pkg::access_size_e core_size,
  input  l1d_geom_pkg::word_t       core_wdata,
  output logic                      core_wait,
  output l1d_geom_pkg::word_t       core_rdata,
  // Memory side
  output logic                      mem_req,
  output logic                      mem_write,
  output l1d_geom_pkg::addr_t       mem_addr,
  input  logic                      mem_wait,
  input  l1d_geom_pkg::word_t       mem_rdata,
  // Tag and data stores
  input  logic                      hit,
  input  l1d_geom_pkg::line_t       line_rd,
  output logic                      lookup,
  output logic [INDEX_BITS-1:0]     index,
  output logic [TAG_BITS-1:0]       lookup_tag,
  output logic                      fill,
  output l1d_geom_pkg::line_t       fill_line,
  output logic                      store_hit
);

  localparam int ADDR_BITS = l1d_geom_pkg::ADDR_BITS;
  localparam int WORD_BITS = l1d_geom_pkg::WORD_BITS;
  localparam int OFFSET_BITS = l1d_geom_pkg::OFFSET_BITS;

  l1d_bus_pkg::ctrl_state_e state;
  l1d_bus_pkg::ctrl_state_e state_next;

  l1d_geom_pkg::addr_t     addr_q;
  logic                    write_q;
  logic                    hit_q;
  l1d_geom_pkg::word_sel_t beat;
  l1d_geom_pkg::word_sel_t req_word;
  l1d_geom_pkg::line_t     line_q;
  l1d_geom_pkg::word_t     rdata_q;
  logic                    beat_done;
  logic                    core_done;
  logic [2:0]              beats_seen;

  assign req_word = l1d_geom_pkg::word_sel_t'(addr_q[OFFSET_BITS-1:2]);
  assign beat_done = (state == l1d_bus_pkg::ST_REFILL_WAIT) && !mem_wait;

  //========================================================================
  // State sequencing
  //========================================================================
  always_comb
  begin
    state_next = state;
    case (state)
      l1d_bus_pkg::ST_IDLE:
        if (core_req)
          state_next = l1d_bus_pkg::ST_LOOKUP;
      l1d_bus_pkg::ST_LOOKUP:
        if (write_q)
          state_next = l1d_bus_pkg::ST_WRITE_WAIT;
        else if (!hit)
          state_next = l1d_bus_pkg::ST_REFILL_ISSUE;
        else
          state_next = l1d_bus_pkg::ST_IDLE;
      l1d_bus_pkg::ST_REFILL_ISSUE:
        state_next = l1d_bus_pkg::ST_REFILL_WAIT;
      l1d_bus_pkg::ST_REFILL_WAIT:
        if (beat_done)
          state_next = (beat == 2'd3) ? l1d_bus_pkg::ST_FILL : l1d_bus_pkg::ST_REFILL_ISSUE;
      l1d_bus_pkg::ST_FILL:
        state_next = l1d_bus_pkg::ST_RESPOND;
      l1d_bus_pkg::ST_RESPOND:
        state_next = l1d_bus_pkg::ST_IDLE;
      l1d_bus_pkg::ST_WRITE_WAIT:
        if (!mem_wait)
          state_next = l1d_bus_pkg::ST_IDLE;
      default:
        state_next = l1d_bus_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= l1d_bus_pkg::ST_IDLE;
      write_q <= 1'b0;
      hit_q <= 1'b0;
      beat <= '0;
      beats_seen <= '0;
    end
    else
    begin
      state <= state_next;
      if (lookup)
        write_q <= core_write;
      if (state == l1d_bus_pkg::ST_LOOKUP)
        hit_q <= hit;
      // Beat count restarts for every refill
      if (state == l1d_bus_pkg::ST_LOOKUP)
        beat <= '0;
      else if (beat_done)
        beat <= beat + 2'd1;
      // Completed beats since the lookup, apart from the word counter
      if (state == l1d_bus_pkg::ST_LOOKUP)
        beats_seen <= '0;
      else if (beat_done)
        beats_seen <= beats_seen + 3'd1;
    end
  end

  // Request address, refill line and the word the core asked for
  always_ff @(posedge clk)
  begin
    if (lookup)
      addr_q <= core_addr;
    if (beat_done)
    begin
      line_q[beat*WORD_BITS +: WORD_BITS] <= mem_rdata;
      if (beat == req_word)
        rdata_q <= mem_rdata;
    end
  end

  //========================================================================
  // Outputs
  //========================================================================
  assign core_done = (state == l1d_bus_pkg::ST_LOOKUP && !write_q && hit)
                  || (state == l1d_bus_pkg::ST_RESPOND)
                  || (state == l1d_bus_pkg::ST_WRITE_WAIT && !mem_wait);
  assign core_wait = (state == l1d_bus_pkg::ST_IDLE) ? core_req : !core_done;

  // Read hit data straight from the array, otherwise the captured word
  assign core_rdata = (state == l1d_bus_pkg::ST_LOOKUP)
                    ? line_rd[req_word*WORD_BITS +: WORD_BITS] : rdata_q;

  // Store pulse goes out in the lookup cycle, refill pulses from the issue state
  assign mem_req = (state == l1d_bus_pkg::ST_LOOKUP && write_q)
                || (state == l1d_bus_pkg::ST_REFILL_ISSUE);
  assign mem_write = write_q && (state == l1d_bus_pkg::ST_LOOKUP
                              || state == l1d_bus_pkg::ST_WRITE_WAIT);
  assign mem_addr = write_q ? {addr_q[ADDR_BITS-1:2], 2'b00}
                            : {addr_q[ADDR_BITS-1:OFFSET_BITS], beat, 2'b00};

  assign lookup = (state == l1d_bus_pkg::ST_IDLE) && core_req;
  assign index = lookup ? core_addr[OFFSET_BITS +: INDEX_BITS]
                        : addr_q[OFFSET_BITS +: INDEX_BITS];
  assign lookup_tag = core_addr[ADDR_BITS-1 -: TAG_BITS];
  assign fill = (state == l1d_bus_pkg::ST_FILL);
  assign fill_line = line_q;
  assign store_hit = (state == l1d_bus_pkg::ST_WRITE_WAIT) && !mem_wait && hit_q;

  //========================================================================
  // Checks
  //========================================================================
  assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req)
    else $error("mem_req high on two consecutive cycles");

  // The fill follows the completion of the fourth beat
  assert property (@(posedge clk) disable iff (rst) fill |-> beats_seen == 3'd4)
    else $error("line fill before four refill beats completed");

  // Store alignment reads the core bus directly, so it must hold still
  assert property (@(posedge clk) disable iff (rst)
    core_req && core_wait |=> core_req && $stable(core_addr) && $stable(core_write)
                              && $stable(core_size) && $stable(core_wdata))
    else $error("core changed its request while the cache was busy");

endmodule

// ==== rtl/l1d_cache.sv ====
//==========================================================================
// L1 data cache top level, direct mapped with write-through stores.
// Core and memory both use a request/wait handshake. INDEX_BITS sets
// the number of sets
//==========================================================================
`timescale 1ns/1ns

module l1d_cache #(
  parameter int INDEX_BITS = 6
) (
  input  logic                      clk,
  input  logic                      rst,
  // Core side
  input  logic                      core_req,
  input  logic                      core_write,
  input  l1d_geom_pkg::addr_t       core_addr,
  input  l1d_bus_pkg::access_size_e core_size,
  input  l1d_geom_pkg::word_t       core_wdata,
  output logic                      core_wait,
  output l1d_geom_pkg::word_t       core_rdata,
  // Memory side
  output logic                      mem_req,
  output logic                      mem_write,
  output l1d_geom_pkg::addr_t       mem_addr,
  output l1d_geom_pkg::word_t       mem_wdata,
  output l1d_bus_pkg::strobe_t      mem_wstrb,
  input  logic                      mem_wait,
  input  l1d_geom_pkg::word_t       mem_rdata
);

  localparam int TAG_BITS = l1d_geom_pkg::ADDR_BITS - INDEX_BITS - l1d_geom_pkg::OFFSET_BITS;

  logic                  hit;
  l1d_geom_pkg::line_t   line_rd;
  logic                  lookup;
  logic [INDEX_BITS-1:0] index;
  logic [TAG_BITS-1:0]   lookup_tag;
  logic                  fill;
  l1d_geom_pkg::line_t   fill_line;
  logic                  store_hit;

  l1d_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_write (core_write),
    .core_addr  (core_addr),
    .core_size  (core_size),
    .core_wdata (core_wdata),
    .core_wait  (core_wait),
    .core_rdata (core_rdata),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wait   (mem_wait),
    .mem_rdata  (mem_rdata),
    .hit        (hit),
    .line_rd    (line_rd),
    .lookup     (lookup),
    .index      (index),
    .lookup_tag (lookup_tag),
    .fill       (fill),
    .fill_line  (fill_line),
    .store_hit  (store_hit)
  );

  l1d_tag_store #(.INDEX_BITS(INDEX_BITS)) u_tag_store (
    .clk        (clk),
    .rst        (rst),
    .lookup     (lookup),
    .index      (index),
    .lookup_tag (lookup_tag),
    .fill       (fill),
    .hit        (hit)
  );

  // Strobe and lane data feed both the memory bus and the hit merge
  l1d_data_store #(.INDEX_BITS(INDEX_BITS)) u_data_store (
    .clk       (clk),
    .index     (index),
    .read      (lookup),
    .fill      (fill),
    .fill_line (fill_line),
    .store_hit (store_hit),
    .word_sel  (core_addr[3:2]),
    .strobe    (mem_wstrb),
    .wdata     (mem_wdata),
    .line_rd   (line_rd)
  );

  l1d_store_align u_store_align (
    .size      (core_size),
    .byte_addr (core_addr[1:0]),
    .wdata     (core_wdata),
    .strobe    (mem_wstrb),
    .lane_data (mem_wdata)
  );

endmodule

// ==== bench/l1d_mem_model.sv ====
//==========================================================================
// Backing memory for the cache testbench. Each single-word beat ends after
// 0 to 3 wait cycles, stores are applied lane by lane under the strobe
//==========================================================================
`timescale 1ns/1ns

module l1d_mem_model #(
  parameter int          WORDS = 4096,
  parameter logic [31:0] FILL_MULT = 32'h0001_0001,
  parameter logic [31:0] SEED = 32'd40477
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 mem_req,
  input  logic                 mem_write,
  input  l1d_geom_pkg::addr_t  mem_addr,
  input  l1d_geom_pkg::word_t  mem_wdata,
  input  l1d_bus_pkg::strobe_t mem_wstrb,
  output logic                 mem_wait,
  output l1d_geom_pkg::word_t  mem_rdata
);

  localparam int AW = $clog2(WORDS);

  l1d_geom_pkg::word_t words [WORDS];
  logic [31:0]         lcg_state;
  logic [31:0]         lcg_succ;
  logic [1:0]          wait_left;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  assign lcg_succ = lcg_next(lcg_state);

  // Every word starts as its word address times an odd constant
  initial
  begin
    for (int i = 0; i < WORDS; i++)
      words[i] = FILL_MULT * l1d_geom_pkg::word_t'(i);
  end

  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      lcg_state <= SEED;
      wait_left <= '0;
      mem_wait <= 1'b0;
      mem_rdata <= '0;
    end
    else if (mem_req)
    begin
      // Wait length from the upper LCG bits
      lcg_state <= lcg_succ;
      wait_left <= lcg_succ[17:16];
      mem_wait <= (lcg_succ[17:16] != 2'd0);
      mem_rdata <= words[mem_addr[AW+1:2]];
      if (mem_write)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (mem_wstrb[b])
            words[mem_addr[AW+1:2]][b*8 +: 8] <= mem_wdata[b*8 +: 8];
        end
      end
    end
    else if (wait_left != 2'd0)
    begin
      wait_left <= wait_left - 2'd1;
      if (wait_left == 2'd1)
        mem_wait <= 1'b0;
    end
  end

endmodule

// ==== bench/l1d_cache_tb.sv ====
//==========================================================================
// Testbench for the L1 data cache. Runs the accesses of the case file
// against the DUT and a memory model, checks data, beats and strobes
//==========================================================================
`timescale 1ns/1ns

module l1d_cache_tb;

  localparam int          INDEX_BITS = 6;
  localparam int          MEM_WORDS = 4096;
  localparam int          CYCLES_PER_CASE = 32;
  localparam logic [31:0] FILL_MULT = 32'h0001_0001;

  logic                      clk;
  logic                      rst;
  logic                      core_req;
  logic                      core_write;
  l1d_geom_pkg::addr_t       core_addr;
  l1d_bus_pkg::access_size_e core_size;
  l1d_geom_pkg::word_t       core_wdata;
  logic                      core_wait;
  l1d_geom_pkg::word_t       core_rdata;
  logic                      mem_req;
  logic                      mem_write;
  l1d_geom_pkg::addr_t       mem_addr;
  l1d_geom_pkg::word_t       mem_wdata;
  l1d_bus_pkg::strobe_t      mem_wstrb;
  logic                      mem_wait;
  l1d_geom_pkg::word_t       mem_rdata;

  // Case table as read from the file
  string               case_name [$];
  logic [7:0]          case_op [$];
  l1d_geom_pkg::addr_t case_addr [$];
  logic [7:0]          case_size [$];
  l1d_geom_pkg::word_t case_data [$];
  int                  case_beats [$];

  // Access in flight, shared with the bus monitor
  string                     cur_name;
  logic                      cur_write;
  l1d_geom_pkg::addr_t       cur_addr;
  l1d_bus_pkg::access_size_e cur_size;
  l1d_geom_pkg::word_t       cur_wdata;
  int                        read_beats = 0;
  int                        write_beats = 0;
  logic                      in_beat = 1'b0;

  l1d_geom_pkg::word_t ref_mem [MEM_WORDS];
  int mismatch_count = 0;
  int fault_count = 0;
  int cycle_count = 0;
  int cycle_limit = 1000;

  l1d_cache #(.INDEX_BITS(INDEX_BITS)) UUT (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_write (core_write),
    .core_addr  (core_addr),
    .core_size  (core_size),
    .core_wdata (core_wdata),
    .core_wait  (core_wait),
    .core_rdata (core_rdata),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .mem_wait   (mem_wait),
    .mem_rdata  (mem_rdata)
  );

  l1d_mem_model #(.WORDS(MEM_WORDS), .FILL_MULT(FILL_MULT)) u_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_wait  (mem_wait),
    .mem_rdata (mem_rdata)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > cycle_limit)
    begin
      $display("Timeout: the cases did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  //========================================================================
  // Helpers
  //========================================================================
  task automatic check_word(input string test, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected)
      else
      begin
        $display("MISMATCH %s %s: expected %08h, actual %08h", test, field, expected, actual);
        mismatch_count++;
      end
  endtask

  function automatic l1d_bus_pkg::access_size_e size_from_char(input logic [7:0] c);
    if (c == "B")
      return l1d_bus_pkg::SIZE_BYTE;
    else if (c == "H")
      return l1d_bus_pkg::SIZE_HALF;
    return l1d_bus_pkg::SIZE_WORD;
  endfunction

  // Lanes a store may touch
  function automatic l1d_bus_pkg::strobe_t expected_strobe(
    input l1d_bus_pkg::access_size_e size, input l1d_geom_pkg::addr_t addr);
    l1d_bus_pkg::strobe_t s;
    for (int lane = 0; lane < 4; lane++)
    begin
      case (size)
        l1d_bus_pkg::SIZE_BYTE: s[lane] = (lane == addr[1:0]);
        l1d_bus_pkg::SIZE_HALF: s[lane] = ((lane / 2) == addr[1]);
        default:                s[lane] = 1'b1;
      endcase
    end
    return s;
  endfunction

  // Byte that a store places on one lane
  function automatic logic [7:0] store_lane(input l1d_bus_pkg::access_size_e size,
                                            input l1d_geom_pkg::word_t data, input int lane);
    case (size)
      l1d_bus_pkg::SIZE_BYTE: return data[7:0];
      l1d_bus_pkg::SIZE_HALF: return data[(lane % 2)*8 +: 8];
      default:                return data[lane*8 +: 8];
    endcase
  endfunction

  task automatic apply_store(input l1d_geom_pkg::addr_t addr,
                             input l1d_bus_pkg::access_size_e size,
                             input l1d_geom_pkg::word_t data);
    l1d_bus_pkg::strobe_t s;
    s = expected_strobe(size, addr);
    for (int lane = 0; lane < 4; lane++)
    begin
      if (s[lane])
        ref_mem[addr[13:2]][lane*8 +: 8] = store_lane(size, data, lane);
    end
  endtask

  task automatic load_cases();
    int fd;
    int n;
    string line;
    string name;
    logic [7:0] op;
    logic [7:0] size;
    l1d_geom_pkg::addr_t addr;
    l1d_geom_pkg::word_t data;
    int beats;
    fd = $fopen("bench/l1d_cache_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the case file bench/l1d_cache_cases.txt");
      fault_count++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#")
        begin
          n = $sscanf(line, "%s %s %h %s %h %d", name, op, addr, size, data, beats);
          assert (n == 6)
            else
            begin
              $display("Case file line could not be parsed: %s", line);
              fault_count++;
            end
          if (n == 6)
          begin
            case_name.push_back(name);
            case_op.push_back(op);
            case_addr.push_back(addr);
            case_size.push_back(size);
            case_data.push_back(data);
            case_beats.push_back(beats);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //========================================================================
  // Memory bus monitor, sampled mid-cycle
  //========================================================================
  always @(negedge clk)
  begin : bus_monitor
    l1d_bus_pkg::strobe_t want;
    want = expected_strobe(cur_size, cur_addr);
    if (!rst && mem_req)
    begin
      assert (!in_beat)
        else
        begin
          $display("Protocol fault in %s: memory request while a beat was still open",
                   cur_name);
          fault_count++;
        end
      in_beat = 1'b1;
      if (mem_write)
      begin
        write_beats++;
        check_word(cur_name, "write address", {cur_addr[31:2], 2'b00}, mem_addr);
        check_word(cur_name, "write strobe", want, mem_wstrb);
        for (int lane = 0; lane < 4; lane++)
        begin
          if (want[lane])
            check_word(cur_name, "write lane", store_lane(cur_size, cur_wdata, lane),
                       mem_wdata[lane*8 +: 8]);
        end
      end
      else
      begin
        // Line aligned, ascending word order
        check_word(cur_name, "read address", {cur_addr[31:4], read_beats[1:0], 2'b00},
                   mem_addr);
        read_beats++;
      end
    end
    else if (in_beat && !mem_wait)
      in_beat = 1'b0;
  end

  //========================================================================
  // Access driver
  //========================================================================
  task automatic run_case(input int i);
    int cycles;
    l1d_geom_pkg::word_t seen;
    cycles = 0;
    cur_name = case_name[i];
    cur_write = (case_op[i] == "W");
    cur_addr = case_addr[i];
    cur_size = size_from_char(case_size[i]);
    cur_wdata = cur_write ? case_data[i] : '0;
    read_beats = 0;
    write_beats = 0;
    core_req = 1'b1;
    core_write = cur_write;
    core_addr = cur_addr;
    core_size = cur_size;
    core_wdata = cur_wdata;
    // Completion edge follows the first cycle with core_wait low
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (core_wait);
    seen = core_rdata;
    @(posedge clk);
    #1;
    if (cur_write)
      apply_store(cur_addr, cur_size, cur_wdata);
    else
    begin
      check_word(cur_name, "read data", case_data[i], seen);
      assert (ref_mem[cur_addr[13:2]] == case_data[i])
        else
        begin
          $display("Case %s expects %08h but the reference memory holds %08h",
                   cur_name, case_data[i], ref_mem[cur_addr[13:2]]);
          fault_count++;
        end
      if (case_beats[i] == 0)
        check_word(cur_name, "hit latency", 2, cycles);
    end
    check_word(cur_name, "read beats", case_beats[i], read_beats);
    check_word(cur_name, "write beats", cur_write ? 1 : 0, write_beats);
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    core_req = 1'b0;
    core_write = 1'b0;
    core_addr = '0;
    core_size = l1d_bus_pkg::SIZE_WORD;
    core_wdata = '0;
    cur_name = "reset";
    cur_write = 1'b0;
    cur_addr = '0;
    cur_size = l1d_bus_pkg::SIZE_WORD;
    cur_wdata = '0;
    for (int i = 0; i < MEM_WORDS; i++)
      ref_mem[i] = FILL_MULT * l1d_geom_pkg::word_t'(i);
    load_cases();
    cycle_limit = case_name.size() * CYCLES_PER_CASE + 16;

    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    assert (!core_wait && !mem_req && !mem_write)
      else
      begin
        $display("Cache outputs were not idle after reset");
        fault_count++;
      end
    @(posedge clk);
    #1;

    for (int i = 0; i < case_name.size(); i++)
      run_case(i);
    core_req = 1'b0;
    core_write = 1'b0;
    repeat (2) @(posedge clk);

    // Write-through leaves memory equal to the reference copy
    for (int i = 0; i < MEM_WORDS; i++)
      check_word($sformatf("memory_word_%0d", i), "contents", ref_mem[i], u_mem.words[i]);

    $display("Checks done for %0d cases: %0d mismatches, %0d protocol faults",
             case_name.size(), mismatch_count, fault_count);
    if (mismatch_count == 0 && fault_count == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== bench/l1d_cache_cases.txt ====
# Columns: name, op (R read, W write), byte address (hex), size (B, H, W),
# store data or expected read word (hex), expected memory read beats
rd_cold             R 00000040 W 00100010 4
rd_hit_word2        R 00000048 W 00120012 0
rd_hit_word3        R 0000004C W 00130013 0
wr_byte_hit         W 00000041 B 000000A5 0
rd_byte_merged      R 00000040 W 0010A510 0
wr_half_hi_hit      W 00000046 H 0000BEEF 0
rd_half_hi_merged   R 00000044 W BEEF0011 0
wr_half_lo_odd      W 0000004D H 00001234 0
rd_half_lo_merged   R 0000004C W 00131234 0
wr_word_hit         W 00000048 W CAFEF00D 0
rd_word_merged      R 00000048 W CAFEF00D 0
wr_word_miss        W 00000104 W 5A5A5A5A 0
rd_after_wr_miss    R 00000104 W 5A5A5A5A 4
rd_hit_refilled     R 0000010C W 00430043 0
wr_byte_miss        W 00000203 B 00000077 0
rd_after_byte_miss  R 00000200 W 77800080 4
rd_evict_a          R 00000440 W 01100110 4
rd_evict_b          R 00000040 W 0010A510 4
rd_evict_a2         R 0000044C W 01130113 4
rd_evict_b2         R 00000048 W CAFEF00D 4
rd_hit_b            R 00000044 W BEEF0011 0
wr_evicted_miss     W 00000444 W 13579BDF 0
rd_evicted_line     R 00000444 W 13579BDF 4
rd_last_set         R 000003FC W 00FF00FF 4
rd_last_set_hit     R 000003F0 W 00FC00FC 0

// ==== filelist.f ====
rtl/l1d_geom_pkg.sv
rtl/l1d_bus_pkg.sv
rtl/l1d_tag_store.sv
rtl/l1d_data_store.sv
rtl/l1d_store_align.sv
rtl/l1d_ctrl.sv
rtl/l1d_cache.sv
bench/l1d_mem_model.sv
bench/l1d_cache_tb.sv

// ==== Bender.yml ====
package:
  name: l1d_cache

sources:
  # Packages ahead of the modules that use them
  - rtl/l1d_geom_pkg.sv
  - rtl/l1d_bus_pkg.sv
  - rtl/l1d_tag_store.sv
  - rtl/l1d_data_store.sv
  - rtl/l1d_store_align.sv
  - rtl/l1d_ctrl.sv
  - rtl/l1d_cache.sv
  - target: test
    files:
      - bench/l1d_mem_model.sv
      - bench/l1d_cache_tb.sv
